// ==== src/cache_pkg.sv ====
// --------------------
// Cache geometry, request type codes, address union
// and the message and control structs
// --------------------
`default_nettype none

package cache_pkg;

  // --------------------
  // Geometry
  // --------------------
  localparam int num_lines      = 16;
  localparam int line_bits      = 128;
  localparam int words_per_line = 4;
  localparam int idx_bits       = 4;
  localparam int tag_bits       = 24;

  // Request type codes that the memory side reuses for read and write
  localparam logic [2:0] req_read  = 3'd0;
  localparam logic [2:0] req_write = 3'd1;
  localparam logic [2:0] req_init  = 3'd2;

  typedef struct packed {
    logic [tag_bits-1:0] tag;
    logic [idx_bits-1:0] idx;
    logic [1:0]          word_off;
    logic [1:0]          byte_off;
  } addr_fields_t;

  // One address word seen flat or split into fields
  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t f;
  } cache_addr_t;

  // --------------------
  // Messages
  // --------------------
  typedef struct packed {
    logic [2:0]  type_;
    logic [7:0]  opaque;  // Returned unchanged with the response
    cache_addr_t addr;
    logic [31:0] data;
  } cache_req_t;

  typedef struct packed {
    logic [2:0]  type_;
    logic [7:0]  opaque;
    logic [31:0] data;
  } cache_resp_t;

  typedef struct packed {
    logic [2:0]           type_;
    logic [31:0]          addr;   // Line aligned
    logic [line_bits-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [line_bits-1:0] data;
  } mem_resp_t;

  // Control unit to datapath
  typedef struct packed {
    logic                       req_en;
    logic                       memresp_en;
    logic                       write_sel;    // 0 processor word, 1 refill line
    logic                       tag_ren;
    logic                       tag_wen;
    logic                       data_ren;
    logic                       data_wen;
    logic [line_bits/8-1:0]     data_wben;
    logic                       evict_en;
    logic                       memaddr_sel;  // 0 victim, 1 request line
    logic                       read_reg_en;
    logic [2:0]                 word_sel;     // 4 gives zero data
    logic [2:0]                 resp_type;
    logic [2:0]                 memreq_type;
  } ctrl_t;

  // Datapath status back to control
  typedef struct packed {
    logic                tag_match;
    logic [2:0]          req_type;
    logic [idx_bits-1:0] idx;
    logic [1:0]          word_off;
  } dstat_t;

endpackage

`default_nettype wire

// ==== src/cache_ctrl.sv ====
// --------------------
// Cache control FSM with per-line valid and dirty bits
// --------------------
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   cachereq_val,
  input  logic   memresp_val,
  input  dstat_t stat,
  output ctrl_t  ctrl,
  output logic   busy,
  output logic   cacheresp_val,
  output logic   memreq_val
);

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_init_write,
    st_write_hit,
    st_read_hit,
    st_evict_req,
    st_evict_wait,
    st_refill_req,
    st_refill_wait,
    st_refill_update,
    st_resp
  } state_t;

  state_t               state;
  state_t               state_nxt;
  logic [num_lines-1:0] valid;
  logic [num_lines-1:0] dirty;
  logic                 hit;
  logic                 take;
  logic [15:0]          word_wben;
  logic                 mem_pending;

  assign hit       = stat.tag_match && valid[stat.idx];
  assign busy      = (state != st_idle) && (state != st_resp);
  assign take      = cachereq_val && !busy;
  assign word_wben = 16'h000f << {stat.word_off, 2'b00};

  // --------------------
  // Next state and datapath controls
  // --------------------
  always_comb begin
    state_nxt     = state;
    ctrl          = '0;
    cacheresp_val = 1'b0;
    memreq_val    = 1'b0;
    case (state)
      st_idle: begin
        ctrl.req_en = take;
        if (take) begin
          state_nxt = st_tag_check;
        end
      end
      st_tag_check: begin
        ctrl.tag_ren     = 1'b1;
        ctrl.data_ren    = 1'b1;
        ctrl.evict_en    = 1'b1;  // Capture victim in case of a miss
        ctrl.read_reg_en = 1'b1;
        if (stat.req_type == req_init) begin
          state_nxt = st_init_write;
        end else if (hit) begin
          state_nxt = (stat.req_type == req_write) ? st_write_hit : st_read_hit;
        end else if (valid[stat.idx] && dirty[stat.idx]) begin
          state_nxt = st_evict_req;
        end else begin
          state_nxt = st_refill_req;
        end
      end
      st_init_write: begin
        ctrl.tag_wen   = 1'b1;
        ctrl.data_wen  = 1'b1;
        ctrl.data_wben = word_wben;
        state_nxt      = st_resp;
      end
      st_write_hit: begin
        ctrl.data_wen  = 1'b1;
        ctrl.data_wben = word_wben;
        state_nxt      = st_resp;
      end
      st_read_hit: begin
        ctrl.data_ren    = 1'b1;
        ctrl.read_reg_en = 1'b1;
        state_nxt        = st_resp;
      end
      st_evict_req: begin
        memreq_val       = 1'b1;
        ctrl.memreq_type = req_write;
        ctrl.memaddr_sel = 1'b0;
        state_nxt        = st_evict_wait;
      end
      st_evict_wait: begin
        if (memresp_val) begin
          state_nxt = st_refill_req;  // Write-back acknowledged
        end
      end
      st_refill_req: begin
        memreq_val       = 1'b1;
        ctrl.memreq_type = req_read;
        ctrl.memaddr_sel = 1'b1;
        state_nxt        = st_refill_wait;
      end
      st_refill_wait: begin
        ctrl.memresp_en = memresp_val;
        if (memresp_val) begin
          state_nxt = st_refill_update;
        end
      end
      st_refill_update: begin
        ctrl.tag_wen   = 1'b1;
        ctrl.data_wen  = 1'b1;
        ctrl.data_wben = '1;
        ctrl.write_sel = 1'b1;
        state_nxt      = (stat.req_type == req_write) ? st_write_hit : st_read_hit;
      end
      st_resp: begin
        cacheresp_val  = 1'b1;
        ctrl.resp_type = stat.req_type;
        ctrl.word_sel  = (stat.req_type == req_read) ? {1'b0, stat.word_off} : 3'd4;
        ctrl.req_en    = take;  // Back-to-back accept
        state_nxt      = take ? st_tag_check : st_idle;
      end
      default: state_nxt = st_idle;
    endcase
  end

  // --------------------
  // State, valid and dirty
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      valid <= '0;
      dirty <= '0;
    end else begin
      state <= state_nxt;
      if (ctrl.tag_wen) begin  // Init or refill installs a clean line
        valid[stat.idx] <= 1'b1;
        dirty[stat.idx] <= 1'b0;
      end
      if (state == st_write_hit) begin
        dirty[stat.idx] <= 1'b1;
      end
    end
  end

  // Memory request outstanding until its response strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_pending <= 1'b0;
    end else if (memreq_val) begin
      mem_pending <= 1'b1;
    end else if (memresp_val) begin
      mem_pending <= 1'b0;
    end
  end

  no_memreq_in_wait: assert property (@(posedge clk) disable iff (rst)
    mem_pending |-> !memreq_val)
    else $error("memreq_val raised while waiting on memory");

  no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
    busy |-> !cachereq_val)
    else $error("cache request issued while busy");

endmodule

`default_nettype wire

// ==== src/cache_dpath.sv ====
// --------------------
// Cache datapath with request and refill registers, tag and data
// arrays, write merge, victim address and response word select
// --------------------
`timescale 1ns/1ps
`default_nettype none

module cache_dpath import cache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  cache_req_t  cachereq,
  input  mem_resp_t   memresp,
  input  ctrl_t       ctrl,
  output dstat_t      stat,
  output cache_resp_t cacheresp,
  output mem_req_t    memreq
);

  cache_req_t           req_q;
  logic [line_bits-1:0] refill_q;

  logic [tag_bits-1:0]  tag_mem  [num_lines];
  logic [line_bits-1:0] data_mem [num_lines];

  logic [idx_bits-1:0]  idx;
  logic [tag_bits-1:0]  tag_rd;
  logic [line_bits-1:0] data_rd;
  logic [line_bits-1:0] wdata;

  cache_addr_t          evict_d;
  cache_addr_t          evict_q;
  logic [31:0]          memaddr;
  logic [line_bits-1:0] read_q;
  logic [31:0]          resp_word;

  // --------------------
  // Input registers
  // --------------------
  always_ff @(posedge clk) begin
    if (ctrl.req_en) begin
      req_q <= cachereq;
    end
    if (ctrl.memresp_en) begin
      refill_q <= memresp.data;
    end
  end

  // --------------------
  // Arrays
  // --------------------
  assign idx     = req_q.addr.f.idx;
  assign tag_rd  = ctrl.tag_ren ? tag_mem[idx] : '0;
  assign data_rd = ctrl.data_ren ? data_mem[idx] : '0;

  // Word copied into every slot and byte enables pick the one that lands
  assign wdata = ctrl.write_sel ? refill_q : {words_per_line{req_q.data}};

  always_ff @(posedge clk) begin
    if (ctrl.tag_wen) begin
      tag_mem[idx] <= req_q.addr.f.tag;
    end
    if (ctrl.data_wen) begin
      for (int b = 0; b < line_bits/8; b++) begin
        if (ctrl.data_wben[b]) begin
          data_mem[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // Victim line address from the stored tag
  always_comb begin
    evict_d          = '0;
    evict_d.f.tag    = tag_rd;
    evict_d.f.idx    = idx;
  end

  always_ff @(posedge clk) begin
    if (ctrl.evict_en) begin
      evict_q <= evict_d;
    end
    if (ctrl.read_reg_en) begin
      read_q <= data_rd;  // Victim line or hit line
    end
  end

  assign memaddr = ctrl.memaddr_sel ? {req_q.addr.raw[31:4], 4'b0000} : evict_q.raw;

  // --------------------
  // Response word
  // --------------------
  always_comb begin
    case (ctrl.word_sel)
      3'd0:    resp_word = read_q[31:0];
      3'd1:    resp_word = read_q[63:32];
      3'd2:    resp_word = read_q[95:64];
      3'd3:    resp_word = read_q[127:96];
      default: resp_word = '0;  // Write and init responses
    endcase
  end

  // --------------------
  // Outgoing structs
  // --------------------
  assign cacheresp = '{type_: ctrl.resp_type, opaque: req_q.opaque, data: resp_word};
  assign memreq    = '{type_: ctrl.memreq_type, addr: memaddr, data: read_q};

  assign stat = '{
    tag_match: (tag_rd == req_q.addr.f.tag),
    req_type:  req_q.type_,
    idx:       idx,
    word_off:  req_q.addr.f.word_off
  };

  word_sel_range: assert property (@(posedge clk) disable iff (rst)
    ctrl.word_sel <= 3'd4)
    else $error("word_sel out of range: %0d", ctrl.word_sel);

endmodule

`default_nettype wire

// ==== src/cache_top.sv ====
// --------------------
// Cache top joining control unit and datapath
// --------------------
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        cachereq_val,
  input  cache_req_t  cachereq,
  output logic        busy,
  output logic        cacheresp_val,
  output cache_resp_t cacheresp,
  output logic        memreq_val,
  output mem_req_t    memreq,
  input  logic        memresp_val,
  input  mem_resp_t   memresp
);

  ctrl_t  ctrl;
  dstat_t stat;

  cache_ctrl i_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cachereq_val  (cachereq_val),
    .memresp_val   (memresp_val),
    .stat          (stat),
    .ctrl          (ctrl),
    .busy          (busy),
    .cacheresp_val (cacheresp_val),
    .memreq_val    (memreq_val)
  );

  cache_dpath i_dpath (
    .clk       (clk),
    .rst       (rst),
    .cachereq  (cachereq),
    .memresp   (memresp),
    .ctrl      (ctrl),
    .stat      (stat),
    .cacheresp (cacheresp),
    .memreq    (memreq)
  );

endmodule

`default_nettype wire

// ==== bench/cache_tb.sv ====
// --------------------
// Cache testbench with a stim file driver, a line memory model with
// random latency, and response and memory traffic checks
// --------------------
`timescale 1ns/1ps
`default_nettype none

module cache_tb import cache_pkg::*; ();

  localparam string stim_path  = "bench/cache_stim.txt";
  localparam int    busy_limit = 20;
  localparam int    resp_limit = 100;  // Covers write-back plus refill at worst latency

  logic        clk = 1'b0;
  logic        rst;
  logic        cachereq_val;
  cache_req_t  cachereq;
  logic        busy;
  logic        cacheresp_val;
  cache_resp_t cacheresp;
  logic        memreq_val;
  mem_req_t    memreq;
  logic        memresp_val;
  mem_resp_t   memresp;

  integer      seed      = 32'he8f8ec39;
  int          errors    = 0;
  int          tests     = 0;
  int          mem_count = 0;
  bit          hung      = 1'b0;
  string       cur_name  = "reset";
  logic [31:0] cur_addr  = '0;

  logic [line_bits-1:0] mem_lines [logic [31:0]];  // Lines written back so far

  cache_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .cachereq_val  (cachereq_val),
    .cachereq      (cachereq),
    .busy          (busy),
    .cacheresp_val (cacheresp_val),
    .cacheresp     (cacheresp),
    .memreq_val    (memreq_val),
    .memreq        (memreq),
    .memresp_val   (memresp_val),
    .memresp       (memresp)
  );

  always #5 clk = ~clk;

  // Untouched memory word holds its byte address xor 5a5a0000
  function automatic logic [line_bits-1:0] line_pattern(input logic [31:0] line_addr);
    logic [line_bits-1:0] pat;
    for (int w = 0; w < words_per_line; w++) begin
      pat[32*w +: 32] = (line_addr + 32'(4*w)) ^ 32'h5a5a0000;
    end
    return pat;
  endfunction

  // --------------------
  // Line memory model
  // --------------------
  initial begin : mem_model
    int          delay;
    logic [31:0] line_addr;
    memresp_val = 1'b0;
    memresp     = '0;
    forever begin
      @(negedge clk);
      memresp_val = 1'b0;
      if (memreq_val) begin
        line_addr = memreq.addr;
        mem_count++;
        if (memreq.type_ == req_write) begin
          // Victim shares the index but not the line of the request
          if (line_addr[7:4] != cur_addr[7:4] || line_addr[31:4] == cur_addr[31:4]) begin
            $display("%s: write-back address %h does not conflict with %h",
                     cur_name, line_addr, cur_addr);
            errors++;
          end
          mem_lines[line_addr] = memreq.data;
        end else if (line_addr != {cur_addr[31:4], 4'h0}) begin
          $display("ERR %s refill address expected %h actual %h",
                   cur_name, {cur_addr[31:4], 4'h0}, line_addr);
          errors++;
        end
        memresp.data = mem_lines.exists(line_addr) ? mem_lines[line_addr]
                                                   : line_pattern(line_addr);
        delay = 1 + ({$random(seed)} % 8);  // 1 to 8 cycles
        repeat (delay) @(negedge clk);
        memresp_val = 1'b1;
      end
    end
  end

  // --------------------
  // Tests
  // --------------------
  task automatic check_reset_idle();
    int err_before;
    err_before = errors;
    repeat (3) begin
      @(negedge clk);
      if ({busy, cacheresp_val, memreq_val} !== 3'b000) begin
        $display("ERR reset strobes expected 000 actual %b%b%b",
                 busy, cacheresp_val, memreq_val);
        errors++;
      end
    end
    tests++;
    $display("reset %s", (errors == err_before) ? "ok" : "FAILED");
  endtask

  task automatic run_request(input string name, input logic [2:0] typ,
                             input logic [7:0] opq, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [31:0] exp_data,
                             input int exp_mem);
    int          waited;
    int          cycles;
    int          err_before;
    cache_resp_t resp;
    err_before = errors;
    cur_name   = name;
    waited     = 0;
    cycles     = 0;
    while (busy && waited < busy_limit) begin
      @(negedge clk);
      waited++;
    end
    if (busy) begin
      $display("%s: busy stayed high before the request", name);
      hung = 1'b1;
    end else begin
      cur_addr           = addr;
      mem_count          = 0;
      cachereq_val       = 1'b1;
      cachereq.type_     = typ;
      cachereq.opaque    = opq;
      cachereq.addr.raw  = addr;
      cachereq.data      = wdata;
      @(negedge clk);  // Accepted on the edge before
      cachereq_val = 1'b0;
      cycles       = 1;
      while (!cacheresp_val && cycles < resp_limit) begin
        @(negedge clk);
        cycles++;
      end
      if (!cacheresp_val) begin
        $display("%s: no response within %0d cycles", name, resp_limit);
        hung = 1'b1;
      end else begin
        resp = cacheresp;
        if (resp.data !== exp_data) begin
          $display("ERR %s data expected %h actual %h", name, exp_data, resp.data);
          errors++;
        end
        if (resp.type_ !== typ) begin
          $display("ERR %s type expected %0d actual %0d", name, typ, resp.type_);
          errors++;
        end
        if (resp.opaque !== opq) begin
          $display("ERR %s opaque expected %h actual %h", name, opq, resp.opaque);
          errors++;
        end
        if (mem_count != exp_mem) begin
          $display("ERR %s memreqs expected %0d actual %0d", name, exp_mem, mem_count);
          errors++;
        end
        // Hits and inits take tag check, array access, then the pulse
        if (exp_mem == 0 && cycles != 3) begin
          $display("ERR %s cycles expected 3 actual %0d", name, cycles);
          errors++;
        end
      end
    end
    tests++;
    $display("%s %s cycles=%0d memreqs=%0d", name,
             (errors == err_before && !hung) ? "ok" : "FAILED", cycles, mem_count);
  endtask

  initial begin : driver
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [2:0]  typ;
    logic [7:0]  opq;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    int          exp_mem;
    rst          = 1'b1;
    cachereq_val = 1'b0;
    cachereq     = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_reset_idle();
    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      $display("cannot open %s", stim_path);
      errors++;
    end else begin
      while (!hung && $fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin  // Skip comments and blanks
          n = $sscanf(line, "%s %h %h %h %h %h %d",
                      name, typ, opq, addr, wdata, exp_data, exp_mem);
          if (n == 7) begin
            run_request(name, typ, opq, addr, wdata, exp_data, exp_mem);
          end else begin
            $display("malformed stim line: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
    $display("tests %0d errors %0d%s", tests, errors, hung ? " timeout" : "");
    if (errors == 0 && !hung) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/cache_stim.txt ====
# name type opaque addr wdata exp_data exp_memreqs
# type 0 read, 1 write, 2 init; hex fields except the decimal memreq count
init_w0      2 01 00001040 11111111 00000000 0
read_w0      0 02 00001040 00000000 11111111 0
init_w1      2 03 00001044 22222222 00000000 0
init_w2      2 04 00001048 33333333 00000000 0
init_w3      2 05 0000104c 44444444 00000000 0
write_hit    1 06 00001044 cafef00d 00000000 0
read_hit_w0  0 07 00001040 00000000 11111111 0
read_hit_w1  0 08 00001044 00000000 cafef00d 0
read_hit_w2  0 09 00001048 00000000 33333333 0
read_hit_w3  0 0a 0000104c 00000000 44444444 0
read_miss    0 0b 00002084 00000000 5a5a2084 1
read_after   0 0c 00002088 00000000 5a5a2088 0
write_line8  1 0d 00002080 0badc0de 00000000 0
read_line8   0 0e 00002080 00000000 0badc0de 0
read_line8b  0 0f 00002088 00000000 5a5a2088 0
write_miss   1 10 000030c4 deadbeef 00000000 1
conflict     0 11 000040c8 00000000 5a5a40c8 2
reread       0 12 000030c4 00000000 deadbeef 1
reread_hit   0 13 000030c0 00000000 5a5a30c0 0
evict_init   0 14 00005048 00000000 5a5a5048 2
back_w1      0 15 00001044 00000000 cafef00d 1
back_w3      0 16 0000104c 00000000 44444444 0
back_w0      0 17 00001040 00000000 11111111 0

// ==== all.f ====
src/cache_pkg.sv
src/cache_ctrl.sv
src/cache_dpath.sv
src/cache_top.sv
bench/cache_tb.sv

// ==== Makefile ====
# Verilator flow for the direct-mapped cache

SIM = obj_dir/Vcache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -f all.f --top-module cache_top

sim:
	verilator --binary --timing --assert -j 0 -f all.f --top-module cache_tb
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir
